/* all.f */
hdl/rp_pkg.sv
hdl/rp_reset_seq.sv
hdl/rp_adc_front.sv
hdl/rp_dac_mix.sv
hdl/rp_trig_exp.sv
hdl/rp_top.sv
testbench/rp_top_chk.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f all.f --top-module tb_top -o tb_sim

sim_out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -q "^TEST PASSED$"

/* testbench/tb_top.sv */
/*
 * testbench for the board datapath: random stimulus, one
 * readback per test, counts and timeout
 */

`timescale 1ns/100ps

module tb_top;

  logic                       adc_clk;
  logic                       rst_n_i;
  logic                       pll_locked_i;
  rp_pkg::adc_pins_t          adc_dat_i;
  rp_pkg::samples_t           gen_smp_i;
  rp_pkg::samples_t           pid_smp_i;
  rp_pkg::samples_t           adc_smp_o;
  rp_pkg::dac_codes_t         dac_dat_o;
  rp_pkg::loop_cfg_t          loop_i;
  rp_pkg::daisy_cfg_t         daisy_i;
  logic [rp_pkg::DAISY_W-1:0] daisy_rx_i;
  logic                       scope_trig_i;
  logic                       gen_trig_i;
  logic                       trig_ext_o;
  logic                       daisy_tx_trig_o;
  logic [rp_pkg::EXP_W-1:0]   exp_p_in_i;
  logic [rp_pkg::EXP_W-1:0]   exp_n_in_i;
  rp_pkg::exp_drive_t         hk_p_i;
  rp_pkg::exp_drive_t         hk_n_i;
  rp_pkg::exp_drive_t         exp_p_o;
  rp_pkg::exp_drive_t         exp_n_o;

  logic [31:0] rnd = 32'h2155_3895;  // xorshift state
  int          test_len [6] = '{150, 150, 150, 150, 150, 160};
  int          timeout_limit;
  int          cycle_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          mism;  // readback mismatches in current test

  rp_top i_dut (.*);

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [13:0] to_offset(input logic [13:0] v);
    return {v[13], ~v[12:0]};  // sign kept, rest inverted
  endfunction

  function automatic logic [13:0] clamp_add(input logic [13:0] a, input logic [13:0] b);
    int s;
    s = int'($signed(a)) + int'($signed(b));
    if (s > 8191) s = 8191;
    else if (s < -8192) s = -8192;
    return s[13:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one cycle of random data inputs, config fixed unless asked
  task automatic drive_random(input bit rand_daisy, input bit extremes);
    @(posedge adc_clk);
    rnd = xorshift32(rnd);
    adc_dat_i <= rnd;
    rnd = xorshift32(rnd);
    gen_smp_i <= rnd[27:0];
    if (extremes && rnd[31:30] == 2'b00) begin
      pid_smp_i <= {rnd[27], {13{~rnd[27]}}, rnd[13], {13{~rnd[13]}}};  // near rails
    end else begin
      rnd = xorshift32(rnd);
      pid_smp_i <= rnd[27:0];
    end
    rnd = xorshift32(rnd);
    daisy_rx_i   <= (rnd[2:0] == 3'd0) ? rnd[31:16] : '0;  // sparse daisy traffic
    scope_trig_i <= rnd[3];
    gen_trig_i   <= rnd[4];
    exp_p_in_i   <= rnd[15:8];
    if (rand_daisy) daisy_i <= rnd[7:5];
    rnd = xorshift32(rnd);
    hk_p_i     <= rnd[15:0];
    hk_n_i     <= rnd[31:16];
    exp_n_in_i <= rnd[7:0];
  endtask

  task automatic run_random(input int n, input bit rand_daisy, input bit extremes);
    repeat (n) drive_random(rand_daisy, extremes);
  endtask

  task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("mismatch test %s: expected %h, actual %h", name, exp_v, act_v);
      mism++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    int new_errs;
    new_errs = i_dut.i_chk.err_cnt - errs_before;
    tests_run++;
    if (mism != 0 || new_errs != 0) begin
      tests_failed++;
      $display("test %s: failed, %0d readback errors, %0d assertion errors",
               name, mism, new_errs);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // fixed pin word, converted sample one cycle later
  task automatic adc_readback(input string name);
    logic [31:0] pins;
    pins = 32'h8003_1ffc;
    @(posedge adc_clk);
    adc_dat_i <= pins;
    @(posedge adc_clk);
    @(negedge adc_clk);
    compare(name, {4'h0, to_offset(pins[31:18]), to_offset(pins[15:2])}, {4'h0, adc_smp_o});
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int e0;
    adc_clk = 1'b0;
    rst_n_i = 1'b0;
    pll_locked_i = 1'b0;
    adc_dat_i = '0;
    gen_smp_i = '0;
    pid_smp_i = '0;
    loop_i = '0;
    daisy_i = '0;
    daisy_rx_i = '0;
    scope_trig_i = 1'b0;
    gen_trig_i = 1'b0;
    exp_p_in_i = '0;
    exp_n_in_i = '0;
    hk_p_i = '0;
    hk_n_i = '0;
    timeout_limit = 0;
    foreach (test_len[i]) timeout_limit += test_len[i] + 4;
    timeout_limit = 2 * (timeout_limit + 2);
    repeat (2) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    // adc conversion
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    run_random(test_len[0], 1'b0, 1'b0);
    adc_readback("adc_conv");
    close_test("adc_conv", e0);

    // dac sum with rail hits
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    run_random(test_len[1], 1'b0, 1'b1);
    @(posedge adc_clk);
    gen_smp_i <= {14'h1f00, 14'h2100};  // +7936 / -7936
    pid_smp_i <= {14'h0400, 14'h3c00};  // +1024 / -1024
    @(posedge adc_clk);
    @(negedge adc_clk);
    compare("dac_sat", {4'h0, to_offset(clamp_add(14'h1f00, 14'h0400)),
                              to_offset(clamp_add(14'h2100, 14'h3c00))}, {4'h0, dac_dat_o});
    close_test("dac_sat", e0);

    // loopback both ways
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    @(posedge adc_clk);
    loop_i <= 2'b01;  // adc from dac
    run_random(test_len[2] / 2, 1'b0, 1'b1);
    loop_i <= 2'b10;  // dac from adc
    run_random(test_len[2] / 2, 1'b0, 1'b1);
    @(posedge adc_clk);
    loop_i <= 2'b01;
    gen_smp_i <= {14'h1000, 14'h0123};
    pid_smp_i <= {14'h1000, 14'h0011};
    @(posedge adc_clk);
    @(negedge adc_clk);
    compare("loopback", {4'h0, clamp_add(14'h1000, 14'h1000), clamp_add(14'h0123, 14'h0011)},
            {4'h0, adc_smp_o});
    @(posedge adc_clk);
    loop_i <= 2'b00;
    close_test("loopback", e0);

    // trigger routing
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    run_random(test_len[3], 1'b1, 1'b0);
    @(posedge adc_clk);
    daisy_i <= 3'b101;  // gen source, sync mode
    daisy_rx_i <= 16'h0040;
    exp_p_in_i <= 8'h01;
    gen_trig_i <= 1'b1;
    scope_trig_i <= 1'b0;
    @(negedge adc_clk);
    compare("trig", 32'h1, {30'h0, trig_ext_o, daisy_tx_trig_o});
    close_test("trig", e0);

    // expansion pad override
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    run_random(test_len[4], 1'b1, 1'b0);
    @(posedge adc_clk);
    daisy_i <= 3'b010;  // pin enable, scope source
    scope_trig_i <= 1'b1;
    hk_n_i <= 16'ha400;
    @(negedge adc_clk);
    compare("exp_pins", 32'ha501, {16'h0, exp_n_o});
    @(posedge adc_clk);
    daisy_i <= '0;
    close_test("exp_pins", e0);

    // post-lock hold, then conversion again
    mism = 0;
    e0 = i_dut.i_chk.err_cnt;
    @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    run_random(test_len[5], 1'b0, 1'b0);
    adc_readback("reset_hold");
    close_test("reset_hold", e0);

    $display("tests run %0d, failed %0d, assertion errors %0d",
             tests_run, tests_failed, i_dut.i_chk.err_cnt);
    if (tests_failed == 0 && i_dut.i_chk.err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: tests did not finish within %0d cycles", timeout_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* testbench/rp_top_chk.sv */
/*
 * checker for the board datapath: conversion, saturation,
 * loopback, trigger routing, pad drive and the post-lock hold
 */

`timescale 1ns/100ps

module rp_top_chk (
  input logic                       adc_clk,
  input logic                       rst_n_i,
  input logic                       pll_locked_i,
  input rp_pkg::adc_pins_t          adc_dat_i,
  input rp_pkg::samples_t           gen_smp_i,
  input rp_pkg::samples_t           pid_smp_i,
  input rp_pkg::samples_t           adc_smp_o,
  input rp_pkg::dac_codes_t         dac_dat_o,
  input rp_pkg::loop_cfg_t          loop_i,
  input rp_pkg::daisy_cfg_t         daisy_i,
  input logic [rp_pkg::DAISY_W-1:0] daisy_rx_i,
  input logic                       scope_trig_i,
  input logic                       gen_trig_i,
  input logic                       trig_ext_o,
  input logic                       daisy_tx_trig_o,
  input logic [rp_pkg::EXP_W-1:0]   exp_p_in_i,
  input rp_pkg::exp_drive_t         hk_p_i,
  input rp_pkg::exp_drive_t         hk_n_i,
  input rp_pkg::exp_drive_t         exp_p_o,
  input rp_pkg::exp_drive_t         exp_n_o
);

  int unsigned err_cnt = 0;  // read by the testbench
  logic        lock_d;
  logic        rst_d;        // board reset released a cycle ago
  int unsigned since_rise;   // cycles after the lock edge, saturates
  logic        core_run;     // core out of reset, from the lock window
  logic        trig_out;     // expected outgoing trigger

  // sign bit kept, magnitude inverted
  function automatic logic [rp_pkg::ADC_DW-1:0] flip(input logic [rp_pkg::ADC_DW-1:0] v);
    return {v[rp_pkg::ADC_DW-1], ~v[rp_pkg::ADC_DW-2:0]};
  endfunction

  function automatic rp_pkg::samples_t from_pins(input rp_pkg::adc_pins_t p);
    rp_pkg::samples_t r;
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      r[ch] = flip(p[ch][rp_pkg::ADC_PIN_W-1 -: rp_pkg::ADC_DW]);  // top bits
    end
    return r;
  endfunction

  function automatic rp_pkg::samples_t sat_sum(input rp_pkg::samples_t a,
                                              input rp_pkg::samples_t b);
    rp_pkg::samples_t r;
    int               s;
    int               smax;
    smax = (1 << (rp_pkg::ADC_DW - 1)) - 1;
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      s = int'(a[ch]) + int'(b[ch]);
      if (s > smax) s = smax;                 // clamp high
      else if (s < -smax - 1) s = -smax - 1;  // clamp low
      r[ch] = s[rp_pkg::ADC_DW-1:0];
    end
    return r;
  endfunction

  function automatic rp_pkg::dac_codes_t to_codes(input rp_pkg::samples_t s);
    rp_pkg::dac_codes_t r;
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      r[ch] = flip(s[ch]);
    end
    return r;
  endfunction

  // lock edge tracker for the hold window
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lock_d     <= 1'b0;
      rst_d      <= 1'b0;
      since_rise <= 1000;
    end else begin
      lock_d <= pll_locked_i;
      rst_d  <= 1'b1;
      if (pll_locked_i && !lock_d) since_rise <= 0;
      else if (since_rise < 1000) since_rise <= since_rise + 1;
    end
  end

  // core held from one cycle after the edge, for RST_MAX cycles
  assign core_run = rst_d && !(since_rise >= 1 && since_rise <= rp_pkg::RST_MAX);
  assign trig_out = daisy_i.trig_src_gen ? gen_trig_i : scope_trig_i;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  a_adc_conv: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (core_run && !loop_i.adc_from_dac) |=> adc_smp_o == from_pins($past(adc_dat_i)))
    else begin
      err_cnt++;
      $error("adc sample not the converted pin word");
    end

  a_dac_sat: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (core_run && !loop_i.dac_from_adc) |=>
      dac_dat_o == to_codes(sat_sum($past(gen_smp_i), $past(pid_smp_i))))
    else begin
      err_cnt++;
      $error("dac code not the saturated sum");
    end

  a_adc_loop: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (core_run && loop_i.adc_from_dac) |=>
      adc_smp_o == sat_sum($past(gen_smp_i), $past(pid_smp_i)))
    else begin
      err_cnt++;
      $error("adc loopback not the dac sum");
    end

  a_dac_loop: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (core_run && loop_i.dac_from_adc) |=> dac_dat_o == to_codes($past(adc_smp_o)))
    else begin
      err_cnt++;
      $error("dac loopback not the adc sample");
    end

  // zero window, edge seen plus two, for RST_MAX samples
  a_hold_zero: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (since_rise >= 2 && since_rise <= rp_pkg::RST_MAX + 1) |->
      (adc_smp_o == '0 && dac_dat_o == '0))
    else begin
      err_cnt++;
      $error("outputs not zero during post-lock hold");
    end

  ////////////////////////////////////////////////////////////
  // triggers and pads, same cycle
  ////////////////////////////////////////////////////////////

  a_trig_ext: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    trig_ext_o == (exp_p_in_i[0] & ~(daisy_i.sync_mode & (|daisy_rx_i))))
    else begin
      err_cnt++;
      $error("external trigger wrong");
    end

  a_trig_tx: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    daisy_tx_trig_o == trig_out)
    else begin
      err_cnt++;
      $error("daisy trigger select wrong");
    end

  a_pad_p: assert property (@(posedge adc_clk) disable iff (!rst_n_i) exp_p_o == hk_p_i)
    else begin
      err_cnt++;
      $error("p side pad drive differs from housekeeping");
    end

  a_pad_n: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    exp_n_o == (daisy_i.trig_pin_en ?
      {hk_n_i.dat[rp_pkg::EXP_W-1:1], trig_out, hk_n_i.dir[rp_pkg::EXP_W-1:1], 1'b1}
      : hk_n_i))
    else begin
      err_cnt++;
      $error("n side pad drive wrong");
    end

endmodule

bind rp_top rp_top_chk i_chk (.*);

/* hdl/rp_top.sv */
/*
 * top level of the kept board logic: reset sequencer, ADC front
 * end, DAC mixer and trigger / expansion router on adc_clk
 */

`timescale 1ns/100ps

module rp_top (
  // clocks and lock
  input  logic                       adc_clk,
  input  logic                       rst_n_i,          // board reset, sync
  input  logic                       pll_locked_i,
  // samples
  input  rp_pkg::adc_pins_t          adc_dat_i,        // raw ADC pins
  input  rp_pkg::samples_t           gen_smp_i,        // generator
  input  rp_pkg::samples_t           pid_smp_i,        // controller
  output rp_pkg::samples_t           adc_smp_o,        // converted ADC samples
  output rp_pkg::dac_codes_t         dac_dat_o,        // DAC codes, both channels
  // configuration
  input  rp_pkg::loop_cfg_t          loop_i,
  input  rp_pkg::daisy_cfg_t         daisy_i,
  // daisy and triggers
  input  logic [rp_pkg::DAISY_W-1:0] daisy_rx_i,
  input  logic                       scope_trig_i,
  input  logic                       gen_trig_i,
  output logic                       trig_ext_o,
  output logic                       daisy_tx_trig_o,
  // expansion pins
  input  logic [rp_pkg::EXP_W-1:0]   exp_p_in_i,
  input  logic [rp_pkg::EXP_W-1:0]   exp_n_in_i,
  input  rp_pkg::exp_drive_t         hk_p_i,
  input  rp_pkg::exp_drive_t         hk_n_i,
  output rp_pkg::exp_drive_t         exp_p_o,
  output rp_pkg::exp_drive_t         exp_n_o
);

  logic             core_rst_n;  // held after lock
  rp_pkg::samples_t dac_smp;     // saturated sum, to ADC loopback

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////

  rp_reset_seq i_reset_seq (
    .adc_clk      (adc_clk     ),
    .rst_n_i      (rst_n_i     ),
    .pll_locked_i (pll_locked_i),
    .core_rst_n_o (core_rst_n  )
  );

  ////////////////////////////////////////////////////////////
  // analog datapath
  ////////////////////////////////////////////////////////////

  rp_adc_front i_adc_front (
    .adc_clk   (adc_clk   ),
    .rst_n_i   (core_rst_n),
    .adc_dat_i (adc_dat_i ),
    .loop_i    (loop_i    ),
    .dac_smp_i (dac_smp   ),
    .adc_smp_o (adc_smp_o )
  );

  rp_dac_mix i_dac_mix (
    .adc_clk   (adc_clk   ),
    .rst_n_i   (core_rst_n),
    .gen_smp_i (gen_smp_i ),
    .pid_smp_i (pid_smp_i ),
    .adc_smp_i (adc_smp_o ),  // registered, no comb loop
    .loop_i    (loop_i    ),
    .dac_smp_o (dac_smp   ),
    .dac_dat_o (dac_dat_o )
  );

  ////////////////////////////////////////////////////////////
  // triggers and expansion pins
  ////////////////////////////////////////////////////////////

  rp_trig_exp i_trig_exp (
    .exp_p_in_i      (exp_p_in_i     ),
    .exp_n_in_i      (exp_n_in_i     ),
    .hk_p_i          (hk_p_i         ),
    .hk_n_i          (hk_n_i         ),
    .daisy_i         (daisy_i        ),
    .daisy_rx_i      (daisy_rx_i     ),
    .scope_trig_i    (scope_trig_i   ),
    .gen_trig_i      (gen_trig_i     ),
    .trig_ext_o      (trig_ext_o     ),
    .daisy_tx_trig_o (daisy_tx_trig_o),
    .exp_p_o         (exp_p_o        ),
    .exp_n_o         (exp_n_o        )
  );

endmodule

/* hdl/rp_trig_exp.sv */
/*
 * trigger and expansion pin router: forms the external trigger,
 * picks the trigger sent on the daisy line and can take over
 * n-side pin 0 as a trigger output, all combinational
 */

`timescale 1ns/100ps

module rp_trig_exp (
  input  logic [rp_pkg::EXP_W-1:0]   exp_p_in_i,       // p-side pad inputs
  input  logic [rp_pkg::EXP_W-1:0]   exp_n_in_i,       // n-side pad inputs
  input  rp_pkg::exp_drive_t         hk_p_i,           // housekeeping drive, p side
  input  rp_pkg::exp_drive_t         hk_n_i,           // housekeeping drive, n side
  input  rp_pkg::daisy_cfg_t         daisy_i,          // daisy mode
  input  logic [rp_pkg::DAISY_W-1:0] daisy_rx_i,       // daisy receive word
  input  logic                       scope_trig_i,     // scope trigger pulse
  input  logic                       gen_trig_i,       // generator trigger pulse
  output logic                       trig_ext_o,       // external trigger to core
  output logic                       daisy_tx_trig_o,  // trigger out on daisy
  output rp_pkg::exp_drive_t         exp_p_o,          // p-side pad drive
  output rp_pkg::exp_drive_t         exp_n_o           // n-side pad drive
);

  logic daisy_trig;    // any bit on the daisy word

  ////////////////////////////////////////////////////////////
  // external trigger
  ////////////////////////////////////////////////////////////

  assign daisy_trig = |daisy_rx_i;

  // p-pin 0 is the trigger input, blanked while a daisy
  // trigger arrives in sync mode
  assign trig_ext_o = exp_p_in_i[0] & ~(daisy_i.sync_mode & daisy_trig);

  ////////////////////////////////////////////////////////////
  // outgoing trigger
  ////////////////////////////////////////////////////////////

  assign daisy_tx_trig_o = daisy_i.trig_src_gen ? gen_trig_i : scope_trig_i;

  ////////////////////////////////////////////////////////////
  // pad drive
  ////////////////////////////////////////////////////////////

  assign exp_p_o = hk_p_i;  // p side untouched

  always_comb begin
    exp_n_o = hk_n_i;                         // default, housekeeping owns all
    if (daisy_i.trig_pin_en) begin
      exp_n_o.dat[0] = daisy_tx_trig_o;       // trigger out on the pin
      exp_n_o.dir[0] = 1'b1;                  // force drive
    end
  end

endmodule

/* hdl/rp_dac_mix.sv */
/*
 * DAC mixer: adds generator and controller samples per channel,
 * saturates, converts back to negative-slope offset code and
 * registers the DAC code, with optional ADC loopback
 */

`timescale 1ns/100ps

module rp_dac_mix (
  input  logic               adc_clk,
  input  logic               rst_n_i,    // core reset, sync, active low
  input  rp_pkg::samples_t   gen_smp_i,  // generator samples
  input  rp_pkg::samples_t   pid_smp_i,  // controller samples
  input  rp_pkg::samples_t   adc_smp_i,  // registered ADC samples
  input  rp_pkg::loop_cfg_t  loop_i,     // loopback config
  output rp_pkg::samples_t   dac_smp_o,  // saturated sum, combinational
  output rp_pkg::dac_codes_t dac_dat_o   // registered DAC codes
);

  logic [rp_pkg::N_CH-1:0][rp_pkg::ADC_DW:0] sum;  // one guard bit
  rp_pkg::samples_t                          sat;
  rp_pkg::dac_codes_t                        code_nxt;

  ////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      // signed operands, sign extends into guard bit
      sum[ch] = $signed(gen_smp_i[ch]) + $signed(pid_smp_i[ch]);
      if (sum[ch][rp_pkg::ADC_DW] ^ sum[ch][rp_pkg::ADC_DW-1]) begin
        // overflow, clamp to max or min by true sign
        sat[ch] = {sum[ch][rp_pkg::ADC_DW],
                   {(rp_pkg::ADC_DW-1){~sum[ch][rp_pkg::ADC_DW]}}};
      end else begin
        sat[ch] = sum[ch][rp_pkg::ADC_DW-1:0];
      end
    end
  end

  assign dac_smp_o = sat;  // also feeds ADC loopback

  ////////////////////////////////////////////////////////////
  // code conversion and select
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      if (loop_i.dac_from_adc) begin
        code_nxt[ch] = rp_pkg::nslope_flip(adc_smp_i[ch]);  // ADC -> DAC
      end else begin
        code_nxt[ch] = rp_pkg::nslope_flip(sat[ch]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // DAC code register
  ////////////////////////////////////////////////////////////

  // both channels leave together, no interleave here
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_dat_o <= '0;  // zero while core held
    end else begin
      dac_dat_o <= code_nxt;
    end
  end

endmodule

/* hdl/rp_adc_front.sv */
/*
 * ADC front end: slices the significant bits of each pin word,
 * converts negative-slope offset code to two's complement and
 * registers it, with optional loopback of the DAC value
 */

`timescale 1ns/100ps

module rp_adc_front (
  input  logic              adc_clk,
  input  logic              rst_n_i,    // core reset, sync, active low
  input  rp_pkg::adc_pins_t adc_dat_i,  // raw ADC pins
  input  rp_pkg::loop_cfg_t loop_i,     // loopback config
  input  rp_pkg::samples_t  dac_smp_i,  // saturated DAC samples, unregistered
  output rp_pkg::samples_t  adc_smp_o   // two's complement samples
);

  rp_pkg::samples_t adc_conv;  // converted, before register

  ////////////////////////////////////////////////////////////
  // slice and convert
  ////////////////////////////////////////////////////////////

  // low pin bits unused on the 14-bit part
  always_comb begin
    for (int ch = 0; ch < rp_pkg::N_CH; ch++) begin
      adc_conv[ch] = rp_pkg::nslope_flip(
        adc_dat_i[ch][rp_pkg::ADC_PIN_W-1 -: rp_pkg::ADC_DW]);
    end
  end

  ////////////////////////////////////////////////////////////
  // sample register
  ////////////////////////////////////////////////////////////

  // one cycle pins to sample
  // loopback replaces both channels at once
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_smp_o <= '0;             // zero while core held
    end else if (loop_i.adc_from_dac) begin
      adc_smp_o <= dac_smp_i;      // digital loop, DAC -> ADC
    end else begin
      adc_smp_o <= adc_conv;
    end
  end

endmodule

/* hdl/rp_reset_seq.sv */
/*
 * reset sequencer: holds the core in reset for a fixed
 * number of adc_clk cycles after the PLL reports lock
 */

`timescale 1ns/100ps

module rp_reset_seq (
  input  logic adc_clk,
  input  logic rst_n_i,       // board reset, sync, active low
  input  logic pll_locked_i,  // PLL lock level
  output logic core_rst_n_o   // registered core reset, active low
);

  logic                         lock_q;     // previous lock level
  logic [rp_pkg::RST_CNT_W-1:0] hold_cnt;   // 0 = idle
  logic                         lock_rise;
  logic                         hold;

  assign lock_rise = pll_locked_i & ~lock_q;
  assign hold      = |hold_cnt;  // any count keeps core in reset

  ////////////////////////////////////////////////////////////
  // lock edge and hold counter
  ////////////////////////////////////////////////////////////

  // lock_q clears on reset, so a PLL already locked at reset
  // release still gets the full settle window
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lock_q   <= 1'b0;
      hold_cnt <= '0;
    end else begin
      lock_q <= pll_locked_i;
      if (!pll_locked_i) begin
        hold_cnt <= '0;                    // lost lock, drop the count
      end else if (lock_rise) begin
        hold_cnt <= rp_pkg::RST_CNT_W'(1);  // edge seen, start
      end else if (hold) begin
        if (hold_cnt < rp_pkg::RST_CNT_LAST) begin
          hold_cnt <= hold_cnt + 1'b1;
        end else begin
          hold_cnt <= '0;                  // window done
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // core reset register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      core_rst_n_o <= 1'b0;
    end else begin
      core_rst_n_o <= ~hold;  // follows counter one cycle later
    end
  end

endmodule

/* hdl/rp_pkg.sv */
/*
 * shared widths, constants and bus types for the analog datapath
 * and the trigger / expansion pin glue, all in the adc_clk domain
 */

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned N_CH      = 2;    // analog channels
  localparam int unsigned ADC_PIN_W = 16;   // raw ADC pin word
  localparam int unsigned ADC_DW    = 14;   // significant bits, top of pin word
  localparam int unsigned DAC_DW    = 14;   // DAC code, same as ADC_DW
  localparam int unsigned EXP_W     = 8;    // expansion pins per side
  localparam int unsigned DAISY_W   = 16;   // daisy receive word

  // core reset hold after PLL lock, in adc_clk cycles
  localparam int unsigned RST_MAX   = 64;
  localparam int unsigned RST_CNT_W = $clog2(RST_MAX + 1);
  localparam logic [RST_CNT_W-1:0] RST_CNT_LAST = RST_CNT_W'(RST_MAX);  // last hold count

  ////////////////////////////////////////////////////////////
  // datapath types
  ////////////////////////////////////////////////////////////

  typedef logic [N_CH-1:0][ADC_PIN_W-1:0] adc_pins_t;   // raw pins per channel
  typedef logic signed [ADC_DW-1:0]       sample_t;     // two's complement
  typedef sample_t [N_CH-1:0]             samples_t;
  typedef logic [N_CH-1:0][DAC_DW-1:0]    dac_codes_t;  // negative-slope offset

  // bit 0 is ADC side, bit 1 DAC side
  typedef struct packed {
    logic dac_from_adc;  // DAC path takes ADC sample
    logic adc_from_dac;  // ADC path takes DAC value
  } loop_cfg_t;

  // bit order as the housekeeping daisy mode word
  typedef struct packed {
    logic trig_src_gen;  // outgoing trigger from generator, else scope
    logic trig_pin_en;   // n-pin 0 becomes trigger output
    logic sync_mode;     // daisy line carries triggers
  } daisy_cfg_t;

  typedef struct packed {
    logic [EXP_W-1:0] dat;  // output data
    logic [EXP_W-1:0] dir;  // 1 = drive
  } exp_drive_t;

  ////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////

  // negative-slope offset <-> two's complement
  // sign bit stays, magnitude bits invert, so the same flip works both ways
  function automatic logic [ADC_DW-1:0] nslope_flip(input logic [ADC_DW-1:0] val);
    return {val[ADC_DW-1], ~val[ADC_DW-2:0]};
  endfunction

endpackage
